// File: logic/traffic_pkg.sv
`default_nettype none

package traffic_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int BYTES_PER_BEAT = 4;
    localparam int CNT_W          = 16;

    // fixed burst attributes of every address.
    localparam logic [2:0] AXI_SIZE_BEAT  = 3'($clog2(BYTES_PER_BEAT));
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;

    typedef struct packed {
        logic [ADDR_W-1:0] base_addr;
        logic [7:0]        burst_len;
        logic [CNT_W-1:0]  num_trans;
        logic [7:0]        max_outs;
        logic [7:0]        gap;
        logic [15:0]       phase;
    } wr_cfg_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    typedef struct packed {
        logic [DATA_W-1:0]   data;
        logic [DATA_W/8-1:0] strb;
        logic                last;
    } axi_w_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        GAP
    } issue_state_e;

endpackage

`default_nettype wire

// File: logic/wr_launch_timer.sv
`default_nettype none

module wr_launch_timer (
    input  logic                clk,
    input  logic                rst,
    input  traffic_pkg::wr_cfg_t cfg,
    input  logic                cfg_valid,
    input  logic                start,
    output traffic_pkg::wr_cfg_t cfg_q,
    output logic                launch
);

    logic        armed;
    logic [15:0] phase_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cfg_q <= '0;
        end
        else if (cfg_valid)
        begin
            cfg_q <= cfg;
        end
    end

    // start only arms the delay, the counter runs from the next cycle.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            armed     <= 1'b0;
            phase_cnt <= '0;
            launch    <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                armed <= 1'b1;
            end
            if (armed)
            begin
                if (phase_cnt != cfg_q.phase)
                begin
                    phase_cnt <= phase_cnt + 16'd1;
                end
                else
                begin
                    launch <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/aw_issue_fsm.sv
`default_nettype none

module aw_issue_fsm (
    input  logic                             clk,
    input  logic                             rst,
    input  traffic_pkg::wr_cfg_t             cfg_q,
    input  logic                             launch,
    input  logic [traffic_pkg::CNT_W-1:0]    outstanding,
    output traffic_pkg::axi_aw_t             aw,
    output logic                             awvalid,
    input  logic                             awready,
    output logic                             aw_fire
);

    import traffic_pkg::*;

    issue_state_e      state;
    logic [CNT_W-1:0]  issued_cnt;
    logic [7:0]        gap_cnt;
    logic [ADDR_W-1:0] addr_q;
    logic [ADDR_W-1:0] addr_step;
    logic              can_issue;

    assign addr_step = (ADDR_W'(cfg_q.burst_len) + 1) * ADDR_W'(BYTES_PER_BEAT);
    assign can_issue = launch && (issued_cnt < cfg_q.num_trans) &&
                       (outstanding < CNT_W'(cfg_q.max_outs));

    assign awvalid = (state == ADDR);
    assign aw_fire = awvalid && awready;

    assign aw.addr  = addr_q;
    assign aw.len   = cfg_q.burst_len;
    assign aw.size  = AXI_SIZE_BEAT;
    assign aw.burst = AXI_BURST_INCR;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= IDLE;
            issued_cnt <= '0;
            gap_cnt    <= '0;
            addr_q     <= '0;
        end
        else
        begin
            unique case (state)
                IDLE:
                begin
                    if (can_issue)
                    begin
                        // first burst starts at the base, the rest follow on.
                        addr_q <= (issued_cnt == '0) ? cfg_q.base_addr : addr_q + addr_step;
                        state  <= ADDR;
                    end
                end
                ADDR:
                begin
                    if (awready)
                    begin
                        issued_cnt <= issued_cnt + 1'b1;
                        if (cfg_q.gap != 8'd0)
                        begin
                            gap_cnt <= cfg_q.gap - 8'd1;
                            state   <= GAP;
                        end
                        else
                        begin
                            state <= IDLE;
                        end
                    end
                end
                GAP:
                begin
                    if (gap_cnt == 8'd0)
                    begin
                        state <= IDLE;
                    end
                    else
                    begin
                        gap_cnt <= gap_cnt - 8'd1;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // an address waiting for the slave must not move or drop.
    assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw changed while waiting for awready");

endmodule

`default_nettype wire

// File: logic/w_beat_gen.sv
`default_nettype none

module w_beat_gen (
    input  logic                 clk,
    input  logic                 rst,
    input  traffic_pkg::wr_cfg_t cfg_q,
    input  logic                 aw_fire,
    output traffic_pkg::axi_w_t  w,
    output logic                 wvalid,
    input  logic                 wready
);

    import traffic_pkg::*;

    logic [CNT_W-1:0] pending;
    logic [7:0]       beat_cnt;
    logic             last_beat;
    logic             w_fire;
    logic             burst_end;

    assign last_beat = (beat_cnt == cfg_q.burst_len);
    assign wvalid    = (pending != '0);
    assign w_fire    = wvalid && wready;
    assign burst_end = w_fire && last_beat;

    // data is the beat index within the burst.
    assign w.data = DATA_W'(beat_cnt);
    assign w.strb = '1;
    assign w.last = last_beat;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pending  <= '0;
            beat_cnt <= '0;
        end
        else
        begin
            pending <= pending + CNT_W'(aw_fire) - CNT_W'(burst_end);
            if (w_fire)
            begin
                if (last_beat)
                begin
                    beat_cnt <= '0;
                end
                else
                begin
                    beat_cnt <= beat_cnt + 8'd1;
                end
            end
        end
    end

    // leaving zero is only possible through a new address, never by wrapping.
    assert property (@(posedge clk) disable iff (rst)
        pending == '0 |=> pending == '0 || $past(aw_fire))
        else $error("pending burst count underflow");

endmodule

`default_nettype wire

// File: logic/b_resp_tracker.sv
`default_nettype none

module b_resp_tracker (
    input  logic                          clk,
    input  logic                          rst,
    input  traffic_pkg::wr_cfg_t          cfg_q,
    input  logic                          cfg_valid,
    input  logic                          aw_fire,
    input  traffic_pkg::axi_resp_e        bresp,
    input  logic                          bvalid,
    output logic                          bready,
    output logic [traffic_pkg::CNT_W-1:0] outstanding,
    output logic                          done,
    output logic                          resp_err
);

    import traffic_pkg::*;

    logic [CNT_W-1:0] b_cnt;
    logic             loaded;
    logic             b_fire;

    assign bready = 1'b1;
    assign b_fire = bvalid && bready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            b_cnt       <= '0;
            loaded      <= 1'b0;
            outstanding <= '0;
            done        <= 1'b0;
            resp_err    <= 1'b0;
        end
        else
        begin
            outstanding <= outstanding + CNT_W'(aw_fire) - CNT_W'(b_fire);
            if (cfg_valid)
            begin
                // a new configuration starts a fresh run.
                b_cnt  <= '0;
                loaded <= 1'b1;
                done   <= 1'b0;
            end
            else
            begin
                b_cnt <= b_cnt + CNT_W'(b_fire);
                done  <= loaded && (b_cnt == cfg_q.num_trans);
            end
            if (b_fire && bresp != OKAY)
            begin
                resp_err <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        outstanding <= CNT_W'(cfg_q.max_outs))
        else $error("outstanding bursts above max_outs");

endmodule

`default_nettype wire

// File: logic/axi_wr_traffic_gen.sv
`default_nettype none

module axi_wr_traffic_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  traffic_pkg::wr_cfg_t   cfg,
    input  logic                   cfg_valid,
    input  logic                   start,
    output traffic_pkg::axi_aw_t   aw,
    output logic                   awvalid,
    input  logic                   awready,
    output traffic_pkg::axi_w_t    w,
    output logic                   wvalid,
    input  logic                   wready,
    input  traffic_pkg::axi_resp_e bresp,
    input  logic                   bvalid,
    output logic                   bready,
    output logic                   done,
    output logic                   resp_err
);

    import traffic_pkg::*;

    wr_cfg_t          cfg_q;
    logic             launch;
    logic             aw_fire;
    logic [CNT_W-1:0] outstanding;

    wr_launch_timer wr_launch_timer_inst (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .cfg_valid (cfg_valid),
        .start     (start),
        .cfg_q     (cfg_q),
        .launch    (launch)
    );

    aw_issue_fsm aw_issue_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_q       (cfg_q),
        .launch      (launch),
        .outstanding (outstanding),
        .aw          (aw),
        .awvalid     (awvalid),
        .awready     (awready),
        .aw_fire     (aw_fire)
    );

    w_beat_gen w_beat_gen_inst (
        .clk     (clk),
        .rst     (rst),
        .cfg_q   (cfg_q),
        .aw_fire (aw_fire),
        .w       (w),
        .wvalid  (wvalid),
        .wready  (wready)
    );

    b_resp_tracker b_resp_tracker_inst (
        .clk         (clk),
        .rst         (rst),
        .cfg_q       (cfg_q),
        .cfg_valid   (cfg_valid),
        .aw_fire     (aw_fire),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .outstanding (outstanding),
        .done        (done),
        .resp_err    (resp_err)
    );

endmodule

`default_nettype wire

// File: test/axi_wr_slave_model.sv
`default_nettype none

module axi_wr_slave_model (
    input  logic                   clk,
    input  logic                   rst,
    output logic                   awready,
    input  traffic_pkg::axi_w_t    w,
    input  logic                   wvalid,
    output logic                   wready,
    output traffic_pkg::axi_resp_e bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic                   slow_resp,
    input  int                     err_burst,
    input  traffic_pkg::axi_resp_e err_code
);

    timeunit 1ns;
    timeprecision 100ps;

    import traffic_pkg::*;

    logic [31:0] lfsr = 32'hf12d_c23b;
    logic        awready_q = 1'b0;
    logic        wready_q = 1'b0;
    logic        bvalid_q = 1'b0;
    axi_resp_e   bresp_q = OKAY;
    axi_resp_e   resp_q[$];
    int          bursts_seen;
    int          delay_left;
    int          draw;
    logic        delay_armed = 1'b0;
    logic        b_taken = 1'b0;

    assign awready = awready_q;
    assign wready  = wready_q;
    assign bvalid  = bvalid_q;
    assign bresp   = bresp_q;

    // galois form of x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // one response per completed burst, in order.
    always @(posedge clk)
    begin
        if (rst)
        begin
            resp_q.delete();
            bursts_seen = 0;
            b_taken     = 1'b0;
        end
        else
        begin
            if (wvalid && wready && w.last)
            begin
                resp_q.push_back((bursts_seen == err_burst) ? err_code : OKAY);
                bursts_seen++;
            end
            b_taken = bvalid && bready;
        end
    end

    always @(negedge clk)
    begin
        if (rst)
        begin
            awready_q   <= 1'b0;
            wready_q    <= 1'b0;
            bvalid_q    <= 1'b0;
            bresp_q     <= OKAY;
            delay_armed = 1'b0;
        end
        else
        begin
            take_bits(1, draw);
            awready_q <= draw[0];
            take_bits(1, draw);
            wready_q <= draw[0];
            if (bvalid_q)
            begin
                if (b_taken)
                begin
                    bvalid_q <= 1'b0;
                end
            end
            else if (resp_q.size() != 0)
            begin
                if (!delay_armed)
                begin
                    take_bits(3, draw);
                    delay_left  = draw + (slow_resp ? 8 : 0);
                    delay_armed = 1'b1;
                end
                if (delay_left == 0)
                begin
                    bresp_q     <= resp_q.pop_front();
                    bvalid_q    <= 1'b1;
                    delay_armed = 1'b0;
                end
                else
                begin
                    delay_left--;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: test/tb_axi_wr_traffic_gen.sv
`default_nettype none

module tb_axi_wr_traffic_gen;

    timeunit 1ns;
    timeprecision 100ps;

    import traffic_pkg::*;

    localparam wr_cfg_t CFG_BASIC = '{base_addr: 32'h1000_0000, burst_len: 8'd3,
        num_trans: 16'd6, max_outs: 8'd4, gap: 8'd0, phase: 16'd10};
    localparam wr_cfg_t CFG_OUTS = '{base_addr: 32'h0000_4000, burst_len: 8'd1,
        num_trans: 16'd8, max_outs: 8'd2, gap: 8'd0, phase: 16'd0};
    localparam wr_cfg_t CFG_GAP = '{base_addr: 32'h2000_0100, burst_len: 8'd2,
        num_trans: 16'd5, max_outs: 8'd8, gap: 8'd5, phase: 16'd40};
    localparam wr_cfg_t CFG_ERR = '{base_addr: 32'h8000_0000, burst_len: 8'd7,
        num_trans: 16'd5, max_outs: 8'd3, gap: 8'd1, phase: 16'd3};

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    wr_cfg_t   cfg = '0;
    logic      cfg_valid = 1'b0;
    logic      start = 1'b0;
    axi_aw_t   aw;
    logic      awvalid;
    logic      awready;
    axi_w_t    w;
    logic      wvalid;
    logic      wready;
    axi_resp_e bresp;
    logic      bvalid;
    logic      bready;
    logic      done;
    logic      resp_err;
    logic      slow_resp = 1'b0;
    int        err_burst = -1;
    axi_resp_e err_code = OKAY;

    wr_cfg_t cur_cfg = '0;
    int      cycle;
    int      timeout_limit;
    int      aw_count;
    int      w_bursts;
    int      beat_idx;
    int      b_count;
    int      start_cyc;
    int      last_aw_cyc;
    int      peak_outs;
    logic    awvalid_seen;
    logic    err_seen;

    axi_wr_traffic_gen axi_wr_traffic_gen_inst (.*);
    axi_wr_slave_model axi_wr_slave_model_inst (.*);

    always #4 clk = ~clk;

    // worst case cycles of one test.
    function automatic int test_budget(input wr_cfg_t c);
        return int'(c.phase) + int'(c.num_trans) * (int'(c.gap) + int'(c.burst_len) + 20) + 100;
    endfunction

    task automatic stop_on_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at cycle %0d", cycle);
    endtask

    task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
        if (got !== exp)
        begin
            $display("ERROR: aw got %h expected %h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_w(input axi_w_t got, input axi_w_t exp);
        if (got !== exp)
        begin
            $display("ERROR: w got %h expected %h", got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("ERROR: %s got %h expected %h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // bus monitor with the expected values of every handshake.
    always @(posedge clk)
    begin : monitor
        axi_aw_t exp_aw;
        axi_w_t  exp_w;
        cycle++;
        if (cycle > timeout_limit)
        begin
            $display("timeout: tests did not complete within %0d cycles", timeout_limit);
            stop_on_failure();
        end
        if (!rst)
        begin
            if (start)
            begin
                start_cyc = cycle;
            end
            if (awvalid && !awvalid_seen)
            begin
                awvalid_seen = 1'b1;
                if (cycle - start_cyc <= int'(cur_cfg.phase))
                begin
                    $display("awvalid came %0d cycles after start, before the phase delay",
                             cycle - start_cyc);
                    stop_on_failure();
                end
            end
            if (wvalid && wready)
            begin
                if (w_bursts >= aw_count)
                begin
                    $display("W beat sent for a burst whose address was never accepted");
                    stop_on_failure();
                end
                exp_w.data = 32'(beat_idx);
                exp_w.strb = '1;
                exp_w.last = (beat_idx == int'(cur_cfg.burst_len));
                check_w(w, exp_w);
                if (exp_w.last)
                begin
                    beat_idx = 0;
                    w_bursts++;
                end
                else
                begin
                    beat_idx++;
                end
            end
            if (awvalid && awready)
            begin
                if (aw_count >= int'(cur_cfg.num_trans))
                begin
                    $display("more address handshakes than configured transactions");
                    stop_on_failure();
                end
                if (aw_count > 0)
                begin
                    if (cycle - last_aw_cyc <= int'(cur_cfg.gap))
                    begin
                        $display("address handshakes only %0d cycles apart", cycle - last_aw_cyc);
                        stop_on_failure();
                    end
                end
                exp_aw.addr  = cur_cfg.base_addr +
                               32'(aw_count * (int'(cur_cfg.burst_len) + 1) * 4);
                exp_aw.len   = cur_cfg.burst_len;
                exp_aw.size  = 3'd2;
                exp_aw.burst = 2'b01;
                check_aw(aw, exp_aw);
                aw_count++;
                last_aw_cyc = cycle;
            end
            check_flag("bready", bready, 1'b1);
            // both flags lag the bus by one cycle.
            check_flag("resp_err", resp_err, err_seen);
            if (b_count < int'(cur_cfg.num_trans))
            begin
                check_flag("done", done, 1'b0);
            end
            if (bvalid && bready)
            begin
                if (bresp != OKAY)
                begin
                    err_seen = 1'b1;
                end
                b_count++;
            end
            if (aw_count - b_count > int'(cur_cfg.max_outs))
            begin
                $display("%0d bursts outstanding, above the limit", aw_count - b_count);
                stop_on_failure();
            end
            if (aw_count - b_count > peak_outs)
            begin
                peak_outs = aw_count - b_count;
            end
        end
    end

    task automatic run_traffic(input wr_cfg_t c);
        @(negedge clk);
        rst          = 1'b1;
        cur_cfg      = c;
        aw_count     = 0;
        w_bursts     = 0;
        beat_idx     = 0;
        b_count      = 0;
        start_cyc    = cycle;
        last_aw_cyc  = 0;
        peak_outs    = 0;
        awvalid_seen = 1'b0;
        err_seen     = 1'b0;
        repeat (8) @(negedge clk);
        rst       = 1'b0;
        cfg       = c;
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done)
        begin
            @(negedge clk);
        end
        check_count("aw handshakes", aw_count, int'(c.num_trans));
        check_count("w bursts", w_bursts, int'(c.num_trans));
        check_count("w beat index", beat_idx, 0);
        check_count("b transfers", b_count, int'(c.num_trans));
        // reloading the configuration clears done.
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        check_flag("done", done, 1'b0);
        repeat (4) @(negedge clk);
    endtask

    task automatic test_basic_burst();
        run_traffic(CFG_BASIC);
    endtask

    task automatic test_outstanding_limit();
        slow_resp = 1'b1;
        run_traffic(CFG_OUTS);
        slow_resp = 1'b0;
        check_count("peak outstanding", peak_outs, 2);
    endtask

    task automatic test_phase_and_gap();
        run_traffic(CFG_GAP);
    endtask

    task automatic test_error_response();
        err_burst = 2;
        err_code  = SLVERR;
        run_traffic(CFG_ERR);
        repeat (5) @(negedge clk);
        check_flag("resp_err", resp_err, 1'b1);
        err_burst = -1;
        err_code  = OKAY;
    endtask

    initial
    begin
        timeout_limit = test_budget(CFG_BASIC) + test_budget(CFG_OUTS) +
                        test_budget(CFG_GAP) + test_budget(CFG_ERR);
        test_basic_burst();
        test_outstanding_limit();
        test_phase_and_gap();
        test_error_response();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
logic/traffic_pkg.sv
logic/wr_launch_timer.sv
logic/aw_issue_fsm.sv
logic/w_beat_gen.sv
logic/b_resp_tracker.sv
logic/axi_wr_traffic_gen.sv
test/axi_wr_slave_model.sv
test/tb_axi_wr_traffic_gen.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_axi_wr_traffic_gen
FILELIST = sim.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep "Simulation finished: PASS" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
